/* hdl/vecproc_consts.svh */
`ifndef VECPROC_CONSTS_SVH
`define VECPROC_CONSTS_SVH

// ===========================================================================
// Datapath widths
// ===========================================================================

// Operand and result word
`define VP_WORD_W 32

// Stream byte on both handshakes
`define VP_BYTE_W 8

// ===========================================================================
// Vector sizing
// ===========================================================================

// Largest accepted N
`define VP_MAX_LEN 16

// Element index, covers 0 .. VP_MAX_LEN-1
`define VP_ADDR_W 4

// Command byte values
`define VP_OP_ADD 8'h01
`define VP_OP_MUL 8'h02
`define VP_OP_DOT 8'h03

`endif

/* hdl/vecproc_pkg.sv */
`default_nettype none

`include "vecproc_consts.svh"

package vecproc_pkg;

    // Data words and stream bytes
    typedef logic [`VP_WORD_W-1:0] word_t;
    typedef logic [`VP_BYTE_W-1:0] byte_t;

    // Element index into an operand memory
    typedef logic [`VP_ADDR_W-1:0] addr_t;

    // One bit wider than addr_t so it can hold VP_MAX_LEN itself
    typedef logic [`VP_ADDR_W:0] len_t;

    // Decoded operation, only legal command bytes map here
    typedef enum logic [1:0] {
        OP_ADD = 2'(`VP_OP_ADD),
        OP_MUL = 2'(`VP_OP_MUL),
        OP_DOT = 2'(`VP_OP_DOT)
    } opcode_t;

    // Operand memory select
    typedef enum logic {
        BANK_A = 1'b0,
        BANK_B = 1'b1
    } bank_t;

endpackage

`default_nettype wire

/* hdl/frame_parser.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vecproc_consts.svh"

module frame_parser (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire vecproc_pkg::byte_t in_data,
    input  wire                  in_valid,
    output logic                 in_ready,
    input  wire                  done,
    output logic                 wr_en,
    output vecproc_pkg::bank_t   wr_bank,
    output vecproc_pkg::addr_t   wr_addr,
    output vecproc_pkg::word_t   wr_data,
    output logic                 start,
    output vecproc_pkg::opcode_t op,
    output vecproc_pkg::len_t    len,
    output logic                 busy,
    output logic                 error
);

    // =======================================================================
    // Frame FSM
    // =======================================================================
    typedef enum logic [2:0] {
        ST_RESET,
        ST_CMD,
        ST_LEN,
        ST_OPA,
        ST_OPB,
        ST_WAIT,
        ST_ERR
    } state_t;

    state_t             state;
    logic [1:0]         byte_cnt;
    vecproc_pkg::addr_t elem_cnt;
    vecproc_pkg::word_t shift_q;
    vecproc_pkg::word_t word_in;
    logic               accept;
    logic               word_done;
    logic               last_elem;

    assign in_ready  = (state == ST_CMD) || (state == ST_LEN) ||
                       (state == ST_OPA) || (state == ST_OPB);
    assign busy      = (state == ST_LEN) || (state == ST_OPA) ||
                       (state == ST_OPB) || (state == ST_WAIT);
    assign accept    = in_valid && in_ready;

    // Little-endian assembly, the new byte lands on top
    assign word_in   = {in_data, shift_q[`VP_WORD_W-1:`VP_BYTE_W]};
    assign word_done = accept && (byte_cnt == 2'd3);
    assign last_elem = ({1'b0, elem_cnt} == len - 1'b1);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= ST_RESET;
            byte_cnt <= '0;
            elem_cnt <= '0;
            op       <= vecproc_pkg::OP_ADD;
            len      <= '0;
            start    <= 1'b0;
            wr_en    <= 1'b0;
            error    <= 1'b0;
        end else begin
            start <= 1'b0;
            wr_en <= 1'b0;
            case (state)
                ST_RESET: begin
                    state <= ST_CMD;
                end
                ST_CMD: begin
                    if (accept) begin
                        byte_cnt <= '0;
                        elem_cnt <= '0;
                        case (in_data)
                            `VP_OP_ADD: op <= vecproc_pkg::OP_ADD;
                            `VP_OP_MUL: op <= vecproc_pkg::OP_MUL;
                            `VP_OP_DOT: op <= vecproc_pkg::OP_DOT;
                            default:    error <= 1'b1;
                        endcase
                        if (in_data == `VP_OP_ADD || in_data == `VP_OP_MUL ||
                            in_data == `VP_OP_DOT) begin
                            state <= ST_LEN;
                        end else begin
                            state <= ST_ERR;
                        end
                    end
                end
                ST_LEN: begin
                    if (accept) begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                    if (word_done) begin
                        if (word_in == '0 || word_in > `VP_MAX_LEN) begin
                            error <= 1'b1;
                            state <= ST_ERR;
                        end else begin
                            len   <= vecproc_pkg::len_t'(word_in);
                            state <= ST_OPA;
                        end
                    end
                end
                ST_OPA, ST_OPB: begin
                    if (accept) begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                    if (word_done) begin
                        wr_en <= 1'b1;
                        if (last_elem) begin
                            elem_cnt <= '0;
                            if (state == ST_OPB) begin
                                start <= 1'b1;
                                state <= ST_WAIT;
                            end else begin
                                state <= ST_OPB;
                            end
                        end else begin
                            elem_cnt <= elem_cnt + 1'b1;
                        end
                    end
                end
                ST_WAIT: begin
                    // Hold off the next frame until the result has left
                    if (done) begin
                        state <= ST_CMD;
                    end
                end
                default: begin
                    // Sticky until reset
                    state <= ST_ERR;
                end
            endcase
        end
    end

    // Word assembly and write payload
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= word_in;
        end
        if (word_done) begin
            wr_bank <= (state == ST_OPB) ? vecproc_pkg::BANK_B : vecproc_pkg::BANK_A;
            wr_addr <= elem_cnt;
            wr_data <= word_in;
        end
    end

endmodule

`default_nettype wire

/* hdl/operand_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vecproc_consts.svh"

module operand_store (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    wr_en,
    input  wire vecproc_pkg::bank_t wr_bank,
    input  wire vecproc_pkg::addr_t wr_addr,
    input  wire vecproc_pkg::word_t wr_data,
    input  wire vecproc_pkg::addr_t rd_addr,
    output vecproc_pkg::word_t     rd_a,
    output vecproc_pkg::word_t     rd_b
);

    // =======================================================================
    // Operand memories
    // =======================================================================

    // One word per element, A and B kept apart so both read together
    vecproc_pkg::word_t mem_a [`VP_MAX_LEN];
    vecproc_pkg::word_t mem_b [`VP_MAX_LEN];

    logic wr_a;
    logic wr_b;

    // Bank decode of the single write port
    assign wr_a = wr_en && (wr_bank == vecproc_pkg::BANK_A);
    assign wr_b = wr_en && (wr_bank == vecproc_pkg::BANK_B);

    always_ff @(posedge clk) begin
        if (wr_a) begin
            mem_a[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_b) begin
            mem_b[wr_addr] <= wr_data;
        end
    end

    // =======================================================================
    // Registered read
    // =======================================================================

    // Same address on both banks, data one cycle after rd_addr
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rd_a <= '0;
            rd_b <= '0;
        end else begin
            rd_a <= mem_a[rd_addr];
            rd_b <= mem_b[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/vector_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_alu (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     start,
    input  wire vecproc_pkg::opcode_t op,
    input  wire vecproc_pkg::len_t  len,
    output vecproc_pkg::addr_t      rd_addr,
    input  wire vecproc_pkg::word_t rd_a,
    input  wire vecproc_pkg::word_t rd_b,
    output vecproc_pkg::byte_t      out_data,
    output logic                    out_valid,
    input  wire                     out_ready,
    output logic                    done
);

    // =======================================================================
    // Sequencer
    // =======================================================================
    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_LOAD,
        S_SEND
    } state_t;

    state_t               state;
    vecproc_pkg::opcode_t op_q;
    vecproc_pkg::len_t    len_q;
    vecproc_pkg::addr_t   elem;
    logic                 last_q;
    logic [1:0]           byte_cnt;
    vecproc_pkg::word_t   acc;
    vecproc_pkg::word_t   out_shift;
    vecproc_pkg::word_t   prod;
    vecproc_pkg::word_t   dot_next;
    vecproc_pkg::word_t   result;
    logic                 last_elem;

    // Low 32 bits only, overflow wraps
    assign prod      = rd_a * rd_b;
    assign dot_next  = acc + prod;
    assign last_elem = ({1'b0, elem} == len_q - 1'b1);
    assign out_data  = out_shift[7:0];

    always_comb begin
        case (op_q)
            vecproc_pkg::OP_ADD: result = rd_a + rd_b;
            vecproc_pkg::OP_MUL: result = prod;
            default:             result = dot_next;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= S_IDLE;
            op_q      <= vecproc_pkg::OP_ADD;
            len_q     <= '0;
            rd_addr   <= '0;
            elem      <= '0;
            last_q    <= 1'b0;
            byte_cnt  <= '0;
            out_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        op_q    <= op;
                        len_q   <= len;
                        rd_addr <= '0;
                        elem    <= '0;
                        state   <= S_FETCH;
                    end
                end
                // Read latency bubble
                S_FETCH: begin
                    state <= S_LOAD;
                end
                // rd_a and rd_b hold element elem here
                S_LOAD: begin
                    rd_addr <= rd_addr + 1'b1;
                    elem    <= elem + 1'b1;
                    last_q  <= last_elem;
                    if (op_q != vecproc_pkg::OP_DOT || last_elem) begin
                        byte_cnt  <= '0;
                        out_valid <= 1'b1;
                        state     <= S_SEND;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                // Next element is fetched while these bytes drain
                S_SEND: begin
                    if (out_ready) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            out_valid <= 1'b0;
                            if (last_q) begin
                                done  <= 1'b1;
                                state <= S_IDLE;
                            end else begin
                                state <= S_LOAD;
                            end
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Accumulator and output shifter
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            acc <= '0;
        end else if (state == S_LOAD) begin
            acc <= dot_next;
        end
        if (state == S_LOAD) begin
            out_shift <= result;
        end else if (state == S_SEND && out_ready) begin
            // Low byte first
            out_shift <= out_shift >> 8;
        end
    end

endmodule

`default_nettype wire

/* hdl/vector_processor.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_processor (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire vecproc_pkg::byte_t in_data,
    input  wire                     in_valid,
    output wire                     in_ready,
    output wire vecproc_pkg::byte_t out_data,
    output wire                     out_valid,
    input  wire                     out_ready,
    output wire                     busy,
    output wire                     error
);

    // =======================================================================
    // Internal connections
    // =======================================================================

    // Parser to store
    wire                       wr_en;
    wire vecproc_pkg::bank_t   wr_bank;
    wire vecproc_pkg::addr_t   wr_addr;
    wire vecproc_pkg::word_t   wr_data;

    // ALU to store and back
    wire vecproc_pkg::addr_t   rd_addr;
    wire vecproc_pkg::word_t   rd_a;
    wire vecproc_pkg::word_t   rd_b;

    // Frame handoff between parser and ALU
    wire                       start;
    wire                       done;
    wire vecproc_pkg::opcode_t op;
    wire vecproc_pkg::len_t    len;

    frame_parser i_frame_parser (
        .clk      (clk),
        .resetn   (resetn),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .done     (done),
        .wr_en    (wr_en),
        .wr_bank  (wr_bank),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .start    (start),
        .op       (op),
        .len      (len),
        .busy     (busy),
        .error    (error)
    );

    operand_store i_operand_store (
        .clk     (clk),
        .resetn  (resetn),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_a    (rd_a),
        .rd_b    (rd_b)
    );

    vector_alu i_vector_alu (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .op        (op),
        .len       (len),
        .rd_addr   (rd_addr),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .done      (done)
    );

endmodule

`default_nettype wire

/* verification/vector_processor_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_processor_chk (
    input wire                     clk,
    input wire                     resetn,
    input wire                     in_ready,
    input wire                     busy,
    input wire                     error,
    input wire vecproc_pkg::byte_t out_data,
    input wire                     out_valid,
    input wire                     out_ready,
    input wire                     start,
    input wire                     done
);

    // Failure counts, read by the testbench at the end of the run
    int stable_fails = 0;
    int error_fails  = 0;
    int ready_fails  = 0;

    // Result of a complete frame still in flight
    logic result_pending;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            result_pending <= 1'b0;
        end else if (start) begin
            result_pending <= 1'b1;
        end else if (done) begin
            result_pending <= 1'b0;
        end
    end

    // ========================================================================
    // Handshake properties
    // ========================================================================

    held_while_stalled: assert property (
        @(posedge clk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else begin
        $error("out_valid or out_data changed while out_ready was low");
        stable_fails = stable_fails + 1;
    end

    // Sticky until the next reset
    error_sticky: assert property (
        @(posedge clk) disable iff (!resetn)
        error |=> error
    ) else begin
        $error("error fell without a reset");
        error_fails = error_fails + 1;
    end

    input_blocked: assert property (
        @(posedge clk) disable iff (!resetn)
        (start || result_pending) |-> busy && !in_ready
    ) else begin
        $error("in_ready high while a frame result was pending");
        ready_fails = ready_fails + 1;
    end

endmodule

`default_nettype wire

/* verification/tb_vector_processor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vecproc_consts.svh"

module tb_vector_processor;

    typedef vecproc_pkg::word_t word_q_t[$];

    localparam int WAIT_LIMIT   = 2000;
    localparam int QUIET_CYCLES = 100;

    logic                    clk;
    logic                    resetn;
    vecproc_pkg::byte_t      in_data;
    logic                    in_valid;
    wire                     in_ready;
    wire vecproc_pkg::byte_t out_data;
    wire                     out_valid;
    logic                    out_ready;
    wire                     busy;
    wire                     error;

    logic [31:0]        lfsr_q     = 32'h8a4a;
    logic [63:0]        stall_mask = '1;
    logic               stall_on   = 1'b0;
    logic               gaps_on    = 1'b0;
    word_q_t            exp_q;
    int                 exp_idx     = 0;
    vecproc_pkg::word_t rx_word     = '0;
    logic [1:0]         rx_cnt      = '0;
    int                 word_fails  = 0;
    int                 bit_fails   = 0;
    int                 extra_fails = 0;
    int                 timeouts    = 0;

    vector_processor i_vector_processor (
        .clk       (clk),
        .resetn    (resetn),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy),
        .error     (error)
    );

    bind vector_processor vector_processor_chk i_vector_processor_chk (
        .clk       (clk),
        .resetn    (resetn),
        .in_ready  (in_ready),
        .busy      (busy),
        .error     (error),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .start     (start),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================================
    // Random source and reference model
    // ========================================================================

    // x^32 + x^22 + x^2 + x + 1, feedback enters at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Results wrap modulo 2^32
    function automatic word_q_t expected_words(input vecproc_pkg::byte_t cmd, input int n,
                                               input word_q_t a, input word_q_t b);
        word_q_t            res;
        logic [63:0]        full;
        vecproc_pkg::word_t sum;
        sum = '0;
        for (int i = 0; i < n; i++) begin
            full = {32'b0, a[i]} * {32'b0, b[i]};
            case (cmd)
                `VP_OP_ADD: res.push_back(a[i] + b[i]);
                `VP_OP_MUL: res.push_back(full[31:0]);
                `VP_OP_DOT: sum = sum + full[31:0];
                default: ;
            endcase
        end
        if (cmd == `VP_OP_DOT) begin
            res.push_back(sum);
        end
        return res;
    endfunction

    task automatic check_word(input string name, input vecproc_pkg::word_t exp_v,
                              input vecproc_pkg::word_t act_v);
        if (act_v !== exp_v) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
            word_fails++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp_v, act_v);
            bit_fails++;
        end
    endtask

    // ========================================================================
    // Output side
    // ========================================================================

    // Stall pattern replayed from a mask drawn by the main sequence
    initial begin
        logic [5:0] pos;
        pos       = '0;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            out_ready = stall_on ? stall_mask[pos] : 1'b1;
            pos       = pos + 6'd1;
        end
    end

    // Rebuild little-endian words and compare in frame order
    always @(posedge clk) begin
        if (!resetn) begin
            rx_cnt = '0;
        end else if (out_valid && out_ready) begin
            rx_word = {out_data, rx_word[31:8]};
            rx_cnt  = rx_cnt + 2'd1;
            if (rx_cnt == 2'd0) begin
                if (exp_idx < exp_q.size()) begin
                    check_word("out_data", exp_q[exp_idx], rx_word);
                    exp_idx++;
                end else begin
                    $display("Result word %h arrived with no frame pending", rx_word);
                    extra_fails++;
                end
            end
        end
    end

    // ========================================================================
    // Input side
    // ========================================================================

    task automatic apply_reset();
        resetn   = 1'b0;
        in_valid = 1'b0;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        check_bit("in_ready", 1'b0, in_ready);
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_byte(input vecproc_pkg::byte_t b);
        int gap;
        int cycles;
        gap = gaps_on ? int'(rand_bits(2)) : 0;
        repeat (gap) @(negedge clk);
        in_data  = b;
        in_valid = 1'b1;
        cycles   = 0;
        while (!in_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!in_ready) begin
            $display("Timeout: in_ready stayed low for %0d cycles", WAIT_LIMIT);
            timeouts++;
        end else begin
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic send_word(input vecproc_pkg::word_t w);
        vecproc_pkg::word_t rest;
        rest = w;
        repeat (4) begin
            send_byte(rest[7:0]);
            rest = rest >> 8;
        end
    endtask

    task automatic send_frame(input vecproc_pkg::byte_t cmd, input int n, input logic big);
        word_q_t a_q;
        word_q_t b_q;
        word_q_t exp_words;
        for (int i = 0; i < n; i++) begin
            a_q.push_back(rand_bits(32));
            b_q.push_back(rand_bits(32));
        end
        // Product of these overflows far beyond 32 bits
        if (big) begin
            a_q[0] = 32'hffff_ffff;
            b_q[0] = 32'hffff_fffe;
        end
        exp_words = expected_words(cmd, n, a_q, b_q);
        foreach (exp_words[i]) begin
            exp_q.push_back(exp_words[i]);
        end
        send_byte(cmd);
        check_bit("busy", 1'b1, busy);
        send_word(vecproc_pkg::word_t'(n));
        foreach (a_q[i]) begin
            send_word(a_q[i]);
        end
        foreach (b_q[i]) begin
            send_word(b_q[i]);
        end
    endtask

    task automatic wait_drained();
        int   cycles;
        logic idle;
        cycles = 0;
        idle   = (exp_idx == exp_q.size()) && !busy && in_ready;
        while (!idle && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            idle = (exp_idx == exp_q.size()) && !busy && in_ready;
        end
        if (!idle) begin
            $display("Timeout: results not drained after %0d cycles", WAIT_LIMIT);
            timeouts++;
        end
    endtask

    // After an error nothing may come out and the input stays closed
    task automatic watch_quiet(input int cycles);
        logic ready_seen;
        logic valid_seen;
        ready_seen = 1'b0;
        valid_seen = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            ready_seen = ready_seen | in_ready;
            valid_seen = valid_seen | out_valid;
        end
        check_bit("in_ready", 1'b0, ready_seen);
        check_bit("out_valid", 1'b0, valid_seen);
        check_bit("error", 1'b1, error);
        check_bit("busy", 1'b0, busy);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        int total;
        resetn   = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        apply_reset();
        check_bit("error", 1'b0, error);
        check_bit("busy", 1'b0, busy);

        send_frame(`VP_OP_ADD, int'(rand_bits(4)) + 1, 1'b0);
        wait_drained();
        send_frame(`VP_OP_MUL, int'(rand_bits(4)) + 1, 1'b1);
        wait_drained();
        send_frame(`VP_OP_DOT, 1, 1'b0);
        wait_drained();
        send_frame(`VP_OP_DOT, `VP_MAX_LEN, 1'b1);
        wait_drained();

        // Stalls and input gaps, three frames queued back to back
        stall_mask[63:32] = rand_bits(32);
        stall_mask[31:0]  = rand_bits(32) | 32'h0000_0001;
        stall_on = 1'b1;
        gaps_on  = 1'b1;
        send_frame(`VP_OP_MUL, int'(rand_bits(4)) + 1, 1'b0);
        send_frame(`VP_OP_DOT, int'(rand_bits(4)) + 1, 1'b0);
        send_frame(`VP_OP_ADD, int'(rand_bits(4)) + 1, 1'b0);
        wait_drained();
        stall_on = 1'b0;
        gaps_on  = 1'b0;

        // Unknown command
        apply_reset();
        send_byte(8'h07);
        check_bit("error", 1'b1, error);
        watch_quiet(QUIET_CYCLES);

        // Lengths of zero and one past the limit
        apply_reset();
        send_byte(`VP_OP_ADD);
        send_word(32'd0);
        check_bit("error", 1'b1, error);
        watch_quiet(QUIET_CYCLES);
        apply_reset();
        send_byte(`VP_OP_MUL);
        send_word(32'd17);
        check_bit("error", 1'b1, error);
        watch_quiet(QUIET_CYCLES);

        total = word_fails + bit_fails + extra_fails + timeouts +
                i_vector_processor.i_vector_processor_chk.stable_fails +
                i_vector_processor.i_vector_processor_chk.error_fails +
                i_vector_processor.i_vector_processor_chk.ready_fails;
        $display("Errors: %0d total, %0d word, %0d bit, %0d unexpected, %0d timeout",
                 total, word_fails, bit_fails, extra_fails, timeouts);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vector_processor.f */
+incdir+hdl
hdl/vecproc_pkg.sv
hdl/frame_parser.sv
hdl/operand_store.sv
hdl/vector_alu.sv
hdl/vector_processor.sv
verification/vector_processor_chk.sv
verification/tb_vector_processor.sv

/* Makefile */
# Verilator build and run for the vector processor testbench

VERILATOR ?= verilator
TOP       ?= tb_vector_processor
FILELIST  ?= vector_processor.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) hdl/vecproc_consts.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears on a line of its own
run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
